// ==== all.f ====
+incdir+design
design/loss_pkg.sv
design/bitmap_if.sv
design/frame_header_parser.sv
design/receive_bitmap.sv
design/loss_tracker.sv
design/loss_monitor_top.sv
sim/tb_loss_monitor.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_loss_monitor

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard design/*.sv design/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_loss_monitor -f all.f -o Vtb_loss_monitor

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_loss_monitor.sv ====
// frame-loss monitor testbench, table of sender cycles with LCG-chosen faults
`timescale 1ns/1ps
`include "loss_settings.svh"

module tb_loss_monitor;

	import loss_pkg::*;

	localparam int NUM_ROWS = 12;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 16 * 64 * 6 + 4 * 1100 + 2000;

	typedef struct {
		logic [15:0]    seg_max;
		bit             drop;
		bit             short_f;   // cut before round byte
		bit             bad_seg;   // segment pushed to 64 and above
		bit             pre_sync;
		bit             scanned;
		int             exp_count;
		tracker_state_e exp_state;
	} row_t;

	logic           clk;
	logic           rst;
	logic           rx_en;
	logic [7:0]     rx_data;
	logic [15:0]    seg_max;
	logic [31:0]    count;
	logic [31:0]    ok;
	logic [31:0]    ng;
	logic           done;
	tracker_state_e state;

	row_t        rows[$];
	logic [31:0] lcg_state = 32'h4667d68a;
	int          done_seen = 0;

	loss_monitor_top dut (
		.clk     (clk),
		.rst     (rst),
		.rx_en   (rx_en),
		.rx_data (rx_data),
		.seg_max (seg_max),
		.count   (count),
		.ok      (ok),
		.ng      (ng),
		.done    (done),
		.state   (state)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (done)
			done_seen <= done_seen + 1; // done pulses so far
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_count(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_state(input string what, input tracker_state_e got,
		input tracker_state_e exp);
		if (got !== exp)
			abort_run($sformatf("ERR @%0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic add_row(input logic [15:0] sm, input bit drop, input bit short_f,
		input bit bad_seg, input bit pre_sync, input bit scanned, input tracker_state_e st);
		row_t r;
		r.seg_max   = sm;
		r.drop      = drop;
		r.short_f   = short_f;
		r.bad_seg   = bad_seg;
		r.pre_sync  = pre_sync;
		r.scanned   = scanned;
		r.exp_count = scanned ? int'(sm) * (`MAX_ROUND + 1) : 0;
		r.exp_state = st;
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(16'd4,  0, 0, 0, 1, 0, st_wait_cycle); // rounds 1..15 before sync
		add_row(16'd4,  0, 0, 0, 0, 0, st_record);     // arms only
		add_row(16'd4,  0, 0, 0, 0, 1, st_wait_cycle);
		add_row(16'd1,  0, 0, 0, 0, 0, st_record);
		add_row(16'd8,  1, 0, 0, 0, 1, st_wait_cycle);
		add_row(16'd1,  0, 0, 0, 0, 0, st_record);
		add_row(16'd8,  0, 1, 0, 0, 1, st_wait_cycle);
		add_row(16'd1,  0, 0, 0, 0, 0, st_record);
		add_row(16'd64, 1, 0, 0, 0, 1, st_wait_cycle);
		add_row(16'd1,  0, 0, 0, 0, 0, st_record);
		add_row(16'd64, 0, 1, 1, 0, 1, st_finished);   // crosses the count limit
		add_row(16'd4,  0, 0, 0, 0, 0, st_finished);
	endtask

	// segment high, segment low, round, pad
	task automatic send_frame(input logic [15:0] seg16, input logic [`ROUND_BITS-1:0] rnd,
		input int nbytes);
		logic [7:0] bytes [4];
		bytes[0] = seg16[15:8];
		bytes[1] = seg16[7:0];
		bytes[2] = 8'(rnd);
		bytes[3] = 8'h5a;
		for (int i = 0; i < nbytes; i++) begin
			@(negedge clk);
			rx_en   = 1'b1;
			rx_data = bytes[i];
		end
		@(negedge clk);
		rx_en   = 1'b0;
		rx_data = 8'h00;
		@(negedge clk);
	endtask

	task automatic send_cycle(input row_t r, output int missed);
		logic [31:0] rv;
		bit          last;
		bit          hit;
		missed = 0;
		for (int rnd = (r.pre_sync ? 1 : 0); rnd <= `MAX_ROUND; rnd++) begin
			for (int seg = 0; seg < int'(r.seg_max); seg++) begin
				last = (rnd == `MAX_ROUND) && (seg == int'(r.seg_max) - 1);
				hit  = 1'b0;
				rv   = 32'd0;
				if (r.scanned && !last && (r.drop || r.short_f || r.bad_seg)) begin
					rv  = next_rand();
					hit = (rv[18:16] == 3'd0);
				end
				if (hit)
					missed++;
				if (!hit)
					send_frame(16'(seg), `ROUND_BITS'(rnd), 4);
				else if (r.short_f && (!r.bad_seg || rv[20]))
					send_frame(16'(seg), `ROUND_BITS'(rnd), 2);
				else if (r.bad_seg)
					send_frame(16'(seg) + (rv[21] ? 16'h0100 : 16'h0040),
						`ROUND_BITS'(rnd), 4); // high byte or bits 7:6 set
			end
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		while (done !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > 1100)
				abort_run("timed out waiting for done after a recorded cycle");
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the test sequence finished");
	end

	initial begin
		int          missed;
		int          base_done;
		logic [31:0] exp_count;
		logic [31:0] exp_ok;
		logic [31:0] exp_ng;
		clk       = 1'b0;
		rst       = 1'b1;
		rx_en     = 1'b0;
		rx_data   = 8'h00;
		seg_max   = 16'd4;
		exp_count = '0;
		exp_ok    = '0;
		exp_ng    = '0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_count("count after reset", count, 32'd0);
		check_count("ok after reset", ok, 32'd0);
		check_count("ng after reset", ng, 32'd0);
		check_flag("done after reset", done, 1'b0);
		repeat (1023) @(negedge clk);
		check_state("state near end of clear", state, st_clear);
		@(negedge clk);
		check_state("state after clear", state, st_sync);

		foreach (rows[i]) begin
			seg_max   = rows[i].seg_max;
			base_done = done_seen;
			send_cycle(rows[i], missed);
			if (rows[i].pre_sync) begin
				check_state("state before round 0", state, st_sync);
				send_frame(16'd0, '0, 4);
			end
			if (rows[i].scanned) begin
				wait_done();
				exp_count = exp_count + 32'(rows[i].exp_count);
				exp_ok    = exp_ok + 32'(rows[i].exp_count - missed);
				exp_ng    = exp_ng + 32'(missed);
			end else begin
				repeat (4) @(negedge clk); // let the last set settle
			end
			check_count("count", count, exp_count);
			check_count("ok", ok, exp_ok);
			check_count("ng", ng, exp_ng);
			check_state("state at end of row", state, rows[i].exp_state);
			if (rows[i].scanned) begin
				@(negedge clk);
				check_flag("done one cycle later", done, 1'b0);
			end else begin
				check_count("done pulses in row", 32'(done_seen), 32'(base_done));
			end
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== design/loss_monitor_top.sv ====
// frame-loss monitor top, header parser into loss tracker over a receive bitmap
`timescale 1ns/1ps
`include "loss_settings.svh"

module loss_monitor_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     rx_en,
	input  logic [7:0]               rx_data,
	input  logic [15:0]              seg_max,
	output logic [31:0]              count,
	output logic [31:0]              ok,
	output logic [31:0]              ng,
	output logic                     done,
	output loss_pkg::tracker_state_e state
);

	logic                   hdr_valid;
	logic [`SEG_BITS-1:0]   hdr_seg;
	logic [`ROUND_BITS-1:0] hdr_round;

	bitmap_if bm_bus ();

	frame_header_parser u_parser (
		.clk       (clk),
		.rst       (rst),
		.rx_en     (rx_en),
		.rx_data   (rx_data),
		.hdr_valid (hdr_valid),
		.hdr_seg   (hdr_seg),
		.hdr_round (hdr_round)
	);

	loss_tracker u_tracker (
		.clk       (clk),
		.rst       (rst),
		.hdr_valid (hdr_valid),
		.hdr_seg   (hdr_seg),
		.hdr_round (hdr_round),
		.seg_max   (seg_max),
		.bm        (bm_bus.tracker),
		.count     (count),
		.ok        (ok),
		.ng        (ng),
		.done      (done),
		.state     (state)
	);

	receive_bitmap u_bitmap (
		.clk (clk),
		.bm  (bm_bus.memory)
	);

endmodule

// ==== design/loss_tracker.sv ====
// loss tracker FSM, records one sender cycle per pass and scans it into loss counters
`timescale 1ns/1ps
`include "loss_settings.svh"

module loss_tracker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hdr_valid,
	input  logic [`SEG_BITS-1:0]   hdr_seg,
	input  logic [`ROUND_BITS-1:0] hdr_round,
	input  logic [15:0]            seg_max,
	bitmap_if.tracker              bm,
	output logic [31:0]            count,
	output logic [31:0]            ok,
	output logic [31:0]            ng,
	output logic                   done,
	output loss_pkg::tracker_state_e state
);

	import loss_pkg::*;

	bitmap_addr_u scan_addr;     // next address for clear or scan
	logic         pend_valid;    // read data returns this cycle
	logic         pend_in_range;
	logic         cycle_end;
	logic         cnt_inc;
	logic         ok_inc;
	logic         ng_inc;
	logic         scan_end;

	// last segment of the last round
	assign cycle_end = hdr_valid && hdr_round == `ROUND_BITS'(`MAX_ROUND)
		&& 16'(hdr_seg) == seg_max - 16'd1;

	assign cnt_inc  = pend_valid && pend_in_range;
	assign ok_inc   = cnt_inc && bm.rd_data;
	assign ng_inc   = cnt_inc && !bm.rd_data;
	assign scan_end = (state == st_scan) && pend_valid && !bm.rd_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_clear;
			scan_addr  <= '0;
			bm.rd_en   <= 1'b0;
			bm.rd_addr <= '0;
			bm.set_en  <= 1'b0;
			pend_valid <= 1'b0;
			done       <= 1'b0;
			count      <= '0;
			ok         <= '0;
			ng         <= '0;
		end else begin
			bm.rd_en   <= 1'b0;
			bm.set_en  <= 1'b0;
			done       <= 1'b0;
			pend_valid <= (state == st_scan) && bm.rd_en;

			if (cnt_inc)
				count <= count + 32'd1;
			if (ok_inc)
				ok <= ok + 32'd1;
			if (ng_inc)
				ng <= ng + 32'd1;

			case (state)
				st_clear: begin
					bm.rd_en        <= 1'b1; // data ignored
					bm.rd_addr      <= scan_addr;
					scan_addr.index <= scan_addr.index + 1'b1;
					if (scan_addr.index == '1)
						state <= st_sync;
				end
				st_sync: begin
					if (hdr_valid && hdr_round == '0)
						state <= st_wait_cycle;
				end
				st_wait_cycle: begin
					if (cycle_end)
						state <= st_record;
				end
				st_record: begin
					bm.set_en <= hdr_valid;
					if (cycle_end) begin
						// first read goes out with the last set
						state            <= st_scan;
						bm.rd_en         <= 1'b1;
						bm.rd_addr.index <= '0;
						scan_addr.index  <= `ADDR_BITS'(1);
					end
				end
				st_scan: begin
					if (scan_addr.index != '0) begin
						bm.rd_en        <= 1'b1;
						bm.rd_addr      <= scan_addr;
						scan_addr.index <= scan_addr.index + 1'b1;
					end
					if (scan_end) begin
						done <= 1'b1;
						if (count + 32'(cnt_inc) >= 32'(`COUNT_LIMIT))
							state <= st_finished;
						else
							state <= st_wait_cycle;
					end
				end
				st_finished: begin
				end
				default: state <= st_clear;
			endcase
		end
	end

	// record address and scan range tag
	always_ff @(posedge clk) begin
		if (hdr_valid) begin
			bm.set_addr.f.seg   <= hdr_seg;
			bm.set_addr.f.round <= hdr_round;
		end
		pend_in_range <= 16'(bm.rd_addr.f.seg) < seg_max;
	end

	a_totals_balance: assert property (@(posedge clk) disable iff (rst)
		state == st_wait_cycle |-> ok + ng == count);

endmodule

// ==== design/receive_bitmap.sv ====
// receive bitmap, one bit per (round, segment) with set and read-and-clear ports
`timescale 1ns/1ps
`include "loss_settings.svh"

module receive_bitmap (
	input logic     clk,
	bitmap_if.memory bm
);

	localparam int DEPTH = 1 << `ADDR_BITS;

	logic mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (bm.rd_en) begin
			bm.rd_data            <= mem[bm.rd_addr.index];
			mem[bm.rd_addr.index] <= 1'b0; // scan clears as it reads
		end
		// later write, so a set beats a clear on the same address
		if (bm.set_en)
			mem[bm.set_addr.index] <= 1'b1;
	end

	a_rd_addr_known: assert property (@(posedge clk)
		bm.rd_en |-> !$isunknown(bm.rd_addr));

endmodule

// ==== design/frame_header_parser.sv ====
// frame header parser, strobes segment and round once the header bytes are in
`timescale 1ns/1ps
`include "loss_settings.svh"

module frame_header_parser (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rx_en,
	input  logic [7:0]             rx_data,
	output logic                   hdr_valid,
	output logic [`SEG_BITS-1:0]   hdr_seg,
	output logic [`ROUND_BITS-1:0] hdr_round
);

	localparam int IDX_BITS = $clog2(`ROUND_POS + 2);

	logic [IDX_BITS-1:0] byte_idx;
	logic [7:0]          seg_hi;
	logic [7:0]          seg_lo;
	logic [15:0]         seg_word;
	logic                seg_ok;
	logic                round_byte;

	assign seg_word   = {seg_hi, seg_lo};
	assign seg_ok     = (seg_word >> `SEG_BITS) == 16'd0; // upper bits must be clear
	assign round_byte = rx_en && (byte_idx == IDX_BITS'(`ROUND_POS));

	// byte position within the burst, sticks past the header
	always_ff @(posedge clk) begin
		if (rst) begin
			byte_idx  <= '0;
			hdr_valid <= 1'b0;
		end else begin
			hdr_valid <= round_byte && seg_ok;
			if (!rx_en)
				byte_idx <= '0;
			else if (byte_idx != IDX_BITS'(`ROUND_POS + 1))
				byte_idx <= byte_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_en && byte_idx == IDX_BITS'(0))
			seg_hi <= rx_data; // high byte first
		if (rx_en && byte_idx == IDX_BITS'(1))
			seg_lo <= rx_data;
		if (round_byte) begin
			hdr_seg   <= seg_lo[`SEG_BITS-1:0];
			hdr_round <= rx_data[`ROUND_BITS-1:0];
		end
	end

	// at most one header per burst, and bursts are never back to back
	a_single_strobe: assert property (@(posedge clk) disable iff (rst)
		hdr_valid |=> !hdr_valid);

endmodule

// ==== design/bitmap_if.sv ====
// bitmap bus between loss tracker and receive bitmap memory
`timescale 1ns/1ps

interface bitmap_if;
	import loss_pkg::*;

	logic         set_en;   // write 1 on this edge
	bitmap_addr_u set_addr;
	logic         rd_en;    // read and clear
	bitmap_addr_u rd_addr;
	logic         rd_data;  // one cycle after rd_en

	modport tracker (
		output set_en,
		output set_addr,
		output rd_en,
		output rd_addr,
		input  rd_data
	);

	modport memory (
		input  set_en,
		input  set_addr,
		input  rd_en,
		input  rd_addr,
		output rd_data
	);

endinterface

// ==== design/loss_pkg.sv ====
// frame-loss monitor shared types for bitmap addressing and tracker state
`include "loss_settings.svh"

package loss_pkg;

	typedef struct packed {
		logic [`ROUND_BITS-1:0] round;
		logic [`SEG_BITS-1:0]   seg;
	} bitmap_fields_t;

	// one bitmap address, walked flat by the scan, filled by field on record
	typedef union packed {
		logic [`ADDR_BITS-1:0] index;
		bitmap_fields_t        f;
	} bitmap_addr_u;

	typedef enum logic [2:0] {
		st_clear,
		st_sync,
		st_wait_cycle,
		st_record,
		st_scan,
		st_finished
	} tracker_state_e;

endpackage

// ==== design/loss_settings.svh ====
// frame-loss monitor field widths, header layout and run limits
`ifndef LOSS_SETTINGS_SVH
`define LOSS_SETTINGS_SVH

// segment field kept in the bitmap, frame carries 16 bits
`define SEG_BITS 6

// round tag width and last round of a sender cycle
`define ROUND_BITS 4
`define MAX_ROUND 15

`define ADDR_BITS (`ROUND_BITS + `SEG_BITS)

// byte offset of the round tag, segment sits in bytes 0 and 1
`define ROUND_POS 2

// expected-frame total that ends the run
`define COUNT_LIMIT 2000

`endif
